//--- hdl/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// ----------------------------------------------------------------------
// Widths of the data path and the instruction fields.
// ----------------------------------------------------------------------
`define DATA_WIDTH    32
`define INSTR_WIDTH   32
`define ALU_OP_WIDTH  4
`define SRC_SEL_WIDTH 2
`define OPCODE_WIDTH  7
`define FUNCT3_WIDTH  3
`define SHAMT_WIDTH   5

// ----------------------------------------------------------------------
// Encodings from the RV32I base opcode map.
// ----------------------------------------------------------------------
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011

// funct3 of the OP and OP-IMM groups.
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

// funct3 of the BRANCH group; 010 and 011 are unused.
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`endif

//--- hdl/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  // ----------------------------------------------------------------------
  // ALU operations.
  // ----------------------------------------------------------------------
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // ----------------------------------------------------------------------
  // Operand pairs fed to the ALU, written as {a, b}.
  // ----------------------------------------------------------------------
  typedef enum logic [`SRC_SEL_WIDTH-1:0] {
    SRC_RS1_RS2 = 2'd0,
    SRC_RS1_IMM = 2'd1,
    SRC_PC_4    = 2'd2,   // Link value for JAL and JALR.
    SRC_PC_IMM  = 2'd3
  } src_sel_e;

  // ----------------------------------------------------------------------
  // Major opcodes handled by this stage.
  // ----------------------------------------------------------------------
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    OPCODE_OP     = `OPC_OP,
    OPCODE_OP_IMM = `OPC_OP_IMM,
    OPCODE_AUIPC  = `OPC_AUIPC,
    OPCODE_JAL    = `OPC_JAL,
    OPCODE_JALR   = `OPC_JALR,
    OPCODE_BRANCH = `OPC_BRANCH
  } opcode_e;

endpackage

//--- hdl/ex_ctrl_if.sv
`timescale 1ns/1ps
`include "rv_params.svh"

interface ex_ctrl_if;
  import rv_pkg::*;

  alu_op_e                  alu_op;
  src_sel_e                 src_sel;
  logic                     branch;   // Reduce the ALU output to a taken bit.
  logic [`FUNCT3_WIDTH-1:0] funct3;
  logic [`DATA_WIDTH-1:0]   imm;
  logic                     illegal;

  modport decoder (
    output alu_op,
    output src_sel,
    output branch,
    output funct3,
    output imm,
    output illegal
  );

  // The illegal flag is taken by the top level, not by the execute unit.
  modport exu (
    input alu_op,
    input src_sel,
    input branch,
    input funct3,
    input imm
  );

endinterface

//--- hdl/rv_alu.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_alu (
  input  rv_pkg::alu_op_e        alu_op,
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,
  output logic [`DATA_WIDTH-1:0] y
);
  import rv_pkg::*;

  logic [`SHAMT_WIDTH-1:0] shamt;
  logic                    lt_signed;
  logic                    lt_unsigned;

  assign shamt       = b[`SHAMT_WIDTH-1:0];  // Only the low bits shift.
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  // ----------------------------------------------------------------------
  // Operation select.
  // ----------------------------------------------------------------------
  always_comb begin
    case (alu_op)
      ALU_ADD: begin
        y = a + b;
      end
      ALU_SUB: begin
        y = a - b;
      end
      ALU_SLL: begin
        y = a << shamt;
      end
      ALU_SLT: begin
        y = {{(`DATA_WIDTH-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        y = {{(`DATA_WIDTH-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      ALU_SRL: begin
        y = a >> shamt;
      end
      ALU_SRA: begin
        y = $unsigned($signed(a) >>> shamt);  // Sign bit fills from the left.
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_AND: begin
        y = a & b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

//--- hdl/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decoder (
  input  logic [`INSTR_WIDTH-1:0] instr,
  ex_ctrl_if.decoder              ctrl
);
  import rv_pkg::*;

  opcode_e                  opcode;
  logic [`FUNCT3_WIDTH-1:0] funct3;
  logic                     alt;      // Bit 30 selects SUB and SRA.
  logic [`DATA_WIDTH-1:0]   imm_i;
  logic [`DATA_WIDTH-1:0]   imm_u;
  logic [`DATA_WIDTH-1:0]   imm_b;
  logic [`DATA_WIDTH-1:0]   imm_j;

  alu_op_e                  alu_op;
  src_sel_e                 src_sel;
  logic                     branch;
  logic [`DATA_WIDTH-1:0]   imm;
  logic                     illegal;

  // Maps funct3 and the alternate bit onto an ALU operation.
  function automatic alu_op_e arith_op(input logic [`FUNCT3_WIDTH-1:0] f3,
                                       input logic alt_op);
    alu_op_e op;
    case (f3)
      `F3_ADD_SUB: op = alt_op ? ALU_SUB : ALU_ADD;
      `F3_SLL:     op = ALU_SLL;
      `F3_SLT:     op = ALU_SLT;
      `F3_SLTU:    op = ALU_SLTU;
      `F3_XOR:     op = ALU_XOR;
      `F3_SRL_SRA: op = alt_op ? ALU_SRA : ALU_SRL;
      `F3_OR:      op = ALU_OR;
      default:     op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign alt    = instr[30];

  // ----------------------------------------------------------------------
  // Immediates by instruction format.
  // ----------------------------------------------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ----------------------------------------------------------------------
  // Control decode.
  // ----------------------------------------------------------------------
  always_comb begin
    alu_op  = ALU_ADD;
    src_sel = SRC_RS1_RS2;
    branch  = 1'b0;
    imm     = '0;
    illegal = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        alu_op = arith_op(funct3, alt);
      end
      OPCODE_OP_IMM: begin
        // There is no SUBI, so bit 30 only counts for the right shifts.
        alu_op  = arith_op(funct3, alt & (funct3 == `F3_SRL_SRA));
        src_sel = SRC_RS1_IMM;
        imm     = imm_i;
      end
      OPCODE_AUIPC: begin
        src_sel = SRC_PC_IMM;
        imm     = imm_u;
      end
      OPCODE_JAL: begin
        src_sel = SRC_PC_4;
        imm     = imm_j;
      end
      OPCODE_JALR: begin
        src_sel = SRC_PC_4;
        imm     = imm_i;
      end
      OPCODE_BRANCH: begin
        branch = 1'b1;
        imm    = imm_b;
        case (funct3)
          `F3_BEQ, `F3_BNE:   alu_op = ALU_SUB;
          `F3_BLT, `F3_BGE:   alu_op = ALU_SLT;
          `F3_BLTU, `F3_BGEU: alu_op = ALU_SLTU;
          default:            illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  assign ctrl.alu_op  = alu_op;
  assign ctrl.src_sel = src_sel;
  assign ctrl.branch  = branch;
  assign ctrl.funct3  = funct3;
  assign ctrl.imm     = imm;
  assign ctrl.illegal = illegal;

endmodule

//--- hdl/rv_exu.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_exu (
  input  logic [`DATA_WIDTH-1:0] pc,
  input  logic [`DATA_WIDTH-1:0] src1,
  input  logic [`DATA_WIDTH-1:0] src2,
  ex_ctrl_if.exu                 ctrl,
  output logic [`DATA_WIDTH-1:0] exu_result
);
  import rv_pkg::*;

  logic [`DATA_WIDTH-1:0] alu_a;
  logic [`DATA_WIDTH-1:0] alu_b;
  logic [`DATA_WIDTH-1:0] alu_y;
  logic                   alu_zero;
  logic                   taken;

  // ----------------------------------------------------------------------
  // Operand selection.
  // ----------------------------------------------------------------------
  always_comb begin
    alu_a = src1;
    alu_b = src2;
    case (ctrl.src_sel)
      SRC_RS1_RS2: begin
        alu_a = src1;
        alu_b = src2;
      end
      SRC_RS1_IMM: begin
        alu_a = src1;
        alu_b = ctrl.imm;
      end
      SRC_PC_4: begin
        alu_a = pc;
        alu_b = `DATA_WIDTH'(4);
      end
      SRC_PC_IMM: begin
        alu_a = pc;
        alu_b = ctrl.imm;
      end
      default: begin
        alu_a = src1;
        alu_b = src2;
      end
    endcase
  end

  rv_alu u_alu (
    .alu_op (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .y      (alu_y)
  );

  assign alu_zero = ~(|alu_y);  // Equal operands when the ALU subtracts.

  // ----------------------------------------------------------------------
  // Branch condition.
  // ----------------------------------------------------------------------
  // SLT and SLTU leave the less-than bit in bit 0 of the ALU output.
  always_comb begin
    case (ctrl.funct3)
      `F3_BEQ:  taken = alu_zero;
      `F3_BNE:  taken = ~alu_zero;
      `F3_BLT:  taken = alu_y[0];
      `F3_BGE:  taken = ~alu_y[0];
      `F3_BLTU: taken = alu_y[0];
      `F3_BGEU: taken = ~alu_y[0];
      default:  taken = 1'b0;
    endcase
  end

  assign exu_result = ctrl.branch ? {{(`DATA_WIDTH-1){1'b0}}, taken} : alu_y;

endmodule

//--- hdl/ex_stage.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   in_valid,
  input  logic [`INSTR_WIDTH-1:0] instr,
  input  logic [`DATA_WIDTH-1:0] pc,
  input  logic [`DATA_WIDTH-1:0] src1,
  input  logic [`DATA_WIDTH-1:0] src2,

  output logic                   out_valid,
  output logic [`DATA_WIDTH-1:0] result,
  output logic                   zero_flag,
  output logic                   illegal
);

  logic [`DATA_WIDTH-1:0] exu_result;

  // ----------------------------------------------------------------------
  // Decode and execute, all in one cycle.
  // ----------------------------------------------------------------------
  ex_ctrl_if ctrl_if ();

  rv_decoder u_decoder (
    .instr (instr),
    .ctrl  (ctrl_if)
  );

  rv_exu u_exu (
    .pc         (pc),
    .src1       (src1),
    .src2       (src2),
    .ctrl       (ctrl_if),
    .exu_result (exu_result)
  );

  // ----------------------------------------------------------------------
  // Output register.
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      illegal   <= 1'b0;
      result    <= '0;
    end else begin
      out_valid <= in_valid;  // One cycle of latency, no stall.
      if (in_valid) begin
        // An illegal instruction leaves a zero result behind.
        result  <= ctrl_if.illegal ? '0 : exu_result;
        illegal <= ctrl_if.illegal;
      end
    end
  end

  assign zero_flag = ~(|result);

endmodule

//--- sim/tb_ex_stage.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_ex_stage;
  import rv_pkg::*;

  // ----------------------------------------------------------------------
  // Run length and timeout.
  // ----------------------------------------------------------------------
  localparam int RAND_RUNS      = 4;
  localparam int RESET_CYCLES   = 6;                  // Reset plus two idle cycles.
  localparam int ALU_CYCLES     = 19 * RAND_RUNS + 8; // Ten OP, nine OP-IMM, edge cases.
  localparam int JUMP_CYCLES    = 3 * RAND_RUNS;
  localparam int BRANCH_CYCLES  = 6 * 5;
  localparam int ILLEGAL_CYCLES = 4;
  localparam int HOLD_CYCLES    = 2;
  localparam int TEST_CYCLES    = RESET_CYCLES + ALU_CYCLES + JUMP_CYCLES +
                                  BRANCH_CYCLES + ILLEGAL_CYCLES + HOLD_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                    clk;
  logic                    rst;
  logic                    in_valid;
  logic [`INSTR_WIDTH-1:0] instr;
  logic [`DATA_WIDTH-1:0]  pc;
  logic [`DATA_WIDTH-1:0]  src1;
  logic [`DATA_WIDTH-1:0]  src2;
  logic                    out_valid;
  logic [`DATA_WIDTH-1:0]  result;
  logic                    zero_flag;
  logic                    illegal;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  ex_stage uut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .instr     (instr),
    .pc        (pc),
    .src1      (src1),
    .src2      (src2),
    .out_valid (out_valid),
    .result    (result),
    .zero_flag (zero_flag),
    .illegal   (illegal)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Compare tasks.
  // ----------------------------------------------------------------------
  task automatic check_word(input string name, input logic [`DATA_WIDTH-1:0] exp,
                            input logic [`DATA_WIDTH-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // ----------------------------------------------------------------------
  // Instruction encoders. Register numbers do not matter to this stage.
  // ----------------------------------------------------------------------
  function automatic logic [31:0] enc_r(input logic alt, input logic [2:0] f3);
    return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd3, OPCODE_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {imm, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [6:0] opc);
    return {imm, 5'd3, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPCODE_JAL};
  endfunction

  // ----------------------------------------------------------------------
  // Reference model.
  // ----------------------------------------------------------------------
  function automatic logic [31:0] arith_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic expected_illegal(input logic [31:0] ins);
    case (ins[6:0])
      OPCODE_OP, OPCODE_OP_IMM, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR: return 1'b0;
      OPCODE_BRANCH: return ins[14:13] == 2'b01;  // funct3 010 and 011.
      default:       return 1'b1;
    endcase
  endfunction

  function automatic logic [31:0] expected_result(input logic [31:0] ins,
                                                  input logic [31:0] pc_v,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [2:0]  f3;
    logic [31:0] imm_i;
    f3    = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    if (expected_illegal(ins))
      return '0;
    case (ins[6:0])
      OPCODE_OP:               return arith_ref(f3, ins[30], a, b);
      OPCODE_OP_IMM:           return arith_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
      OPCODE_AUIPC:            return pc_v + {ins[31:12], 12'b0};
      OPCODE_JAL, OPCODE_JALR: return pc_v + 32'd4;
      default:                 return {31'b0, branch_taken(f3, a, b)};
    endcase
  endfunction

  // Called on a falling edge; checks on the next falling edge, so the next call
  // drives in the same cycle and issue stays back to back.
  task automatic issue_check(input string name, input logic [31:0] ins,
                             input logic [31:0] pc_v, input logic [31:0] a,
                             input logic [31:0] b);
    logic [31:0] exp_res;
    logic        exp_ill;
    exp_ill  = expected_illegal(ins);
    exp_res  = expected_result(ins, pc_v, a, b);
    in_valid = 1'b1;
    instr    = ins;
    pc       = pc_v;
    src1     = a;
    src2     = b;
    @(posedge clk);
    @(negedge clk);
    check_flag({name, " out_valid"}, 1'b1, out_valid);
    check_word(name, exp_res, result);
    check_flag({name, " zero_flag"}, exp_res == '0, zero_flag);
    check_flag({name, " illegal"}, exp_ill, illegal);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests.
  // ----------------------------------------------------------------------
  task automatic test_reset();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_flag("reset out_valid", 1'b0, out_valid);
    check_flag("reset illegal", 1'b0, illegal);
    check_word("reset result", '0, result);
    check_flag("reset zero_flag", 1'b1, zero_flag);
    rst = 1'b0;
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_flag("idle out_valid", 1'b0, out_valid);
    end
  endtask

  task automatic test_alu_ops();
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
      alt = (k >= 8);
      repeat (RAND_RUNS) begin
        issue_check($sformatf("op f3=%0d alt=%0d", f3, alt), enc_r(alt, f3),
                    $urandom, $urandom, $urandom);
      end
      if (k != 8) begin  // No SUBI in RV32I.
        repeat (RAND_RUNS) begin
          imm = (f3 == 3'b001 || f3 == 3'b101) ? {1'b0, alt, 5'b0, 5'($urandom)}
                                               : 12'($urandom);
          issue_check($sformatf("op-imm f3=%0d alt=%0d", f3, alt),
                      enc_i(imm, f3, OPCODE_OP_IMM), $urandom, $urandom, $urandom);
        end
      end
    end
    issue_check("sll by 31", enc_r(1'b0, 3'b001), '0, 32'd1, 32'd31);
    issue_check("srl by 31", enc_r(1'b0, 3'b101), '0, 32'h8000_0000, 32'd31);
    issue_check("sra by 31", enc_r(1'b1, 3'b101), '0, 32'h8000_0000, 32'd31);
    issue_check("srai by 31", enc_i(12'h41f, 3'b101, OPCODE_OP_IMM), '0,
                32'h8000_0000, '0);
    issue_check("slt min", enc_r(1'b0, 3'b010), '0, 32'h8000_0000, 32'd1);
    issue_check("sltu min", enc_r(1'b0, 3'b011), '0, 32'h8000_0000, 32'd1);
    issue_check("sub overflow", enc_r(1'b1, 3'b000), '0, 32'h8000_0000, 32'd1);
    issue_check("add wrap", enc_r(1'b0, 3'b000), '0, 32'hffff_ffff, 32'd1);
  endtask

  task automatic test_upper_jump();
    repeat (RAND_RUNS) begin
      issue_check("auipc", enc_u(20'($urandom), OPCODE_AUIPC), $urandom & ~32'd3,
                  $urandom, $urandom);
      issue_check("jal", enc_j(21'($urandom)), $urandom & ~32'd3, $urandom, $urandom);
      issue_check("jalr", enc_i(12'($urandom), 3'b000, OPCODE_JALR), $urandom & ~32'd3,
                  $urandom, $urandom);
    end
  endtask

  task automatic test_branches();
    logic [2:0]  conds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [31:0] op_a  [5] = '{32'h1234_5678, 32'd3, 32'd7, 32'hffff_ffff, 32'd1};
    logic [31:0] op_b  [5] = '{32'h1234_5678, 32'd7, 32'd3, 32'd1, 32'hffff_ffff};
    foreach (conds[c]) begin
      foreach (op_a[p]) begin
        issue_check($sformatf("branch f3=%0d pair %0d", conds[c], p),
                    enc_b(conds[c], 13'($urandom) & ~13'd1), $urandom, op_a[p], op_b[p]);
      end
    end
  endtask

  task automatic test_illegal();
    issue_check("lui opcode", enc_u(20'habcde, 7'b0110111), 32'h100, 32'd5, 32'd6);
    issue_check("load opcode", enc_i(12'h004, 3'b010, 7'b0000011), 32'h100, 32'd5, 32'd6);
    issue_check("branch f3=2", enc_b(3'b010, 13'h010), 32'h100, 32'd5, 32'd5);
    issue_check("branch f3=3", enc_b(3'b011, 13'h010), 32'h100, 32'd5, 32'd6);
  endtask

  // The data registers keep their value while nothing valid enters.
  task automatic test_idle_hold();
    logic [31:0] held;
    held = expected_result(enc_r(1'b0, 3'b110), '0, 32'h00f0_0000, 32'h0000_0f0f);
    issue_check("hold setup", enc_r(1'b0, 3'b110), '0, 32'h00f0_0000, 32'h0000_0f0f);
    repeat (HOLD_CYCLES - 1) begin
      in_valid = 1'b0;
      instr    = enc_r(1'b0, 3'b000);
      src1     = $urandom;
      src2     = $urandom;
      @(posedge clk);
      @(negedge clk);
      check_flag("hold out_valid", 1'b0, out_valid);
      check_word("hold result", held, result);
    end
  endtask

  initial begin
    int unsigned seed_val;
    clk      = 1'b0;
    rst      = 1'b1;
    in_valid = 1'b0;
    instr    = '0;
    pc       = '0;
    src1     = '0;
    src2     = '0;
    seed_val = $urandom(32'hff41);

    test_reset();
    test_alu_ops();
    test_upper_jump();
    test_branches();
    test_illegal();
    test_idle_hold();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/ex_ctrl_if.sv
hdl/rv_alu.sv
hdl/rv_decoder.sv
hdl/rv_exu.sv
hdl/ex_stage.sv
sim/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/ex_ctrl_if.sv
      - hdl/rv_alu.sv
      - hdl/rv_decoder.sv
      - hdl/rv_exu.sv
      - hdl/ex_stage.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - sim/tb_ex_stage.sv
